/* build.f */
dtlb_pkg.sv
dtlb_array_if.sv
dtlb_entry_array.sv
dtlb_ctrl.sv
dtlb_fault_check.sv
dtlb_top.sv
tb_ptw_model.sv
tb_dtlb.sv

/* dtlb_array_if.sv */
`timescale 1ns/1ps

interface dtlb_array_if;
  import dtlb_pkg::*;

  // Set read and tag compare, driven by the controller
  vpn_t       lookup_vpn;

  // Replacement update for the compare result seen this cycle
  logic       hit_update;

  // Fill from the walker, written into the victim way
  logic       fill_we;
  vpn_t       fill_vpn;
  ppn_t       fill_ppn;
  pte_flags_t fill_flags;

  // Invalidate every entry
  logic       clear;

  // Registered compare result, one clock after lookup_vpn
  logic       hit;
  logic       hit_way;

  // Registered translation of the hit way or the filled way
  ppn_t       entry_ppn;
  pte_flags_t entry_flags;

  modport ctrl (
    output lookup_vpn, hit_update, fill_we, fill_vpn, fill_ppn, fill_flags, clear,
    input  hit, hit_way, entry_ppn, entry_flags
  );

  modport array (
    input  lookup_vpn, hit_update, fill_we, fill_vpn, fill_ppn, fill_flags, clear,
    output hit, hit_way, entry_ppn, entry_flags
  );

endinterface

/* dtlb_ctrl.sv */
`timescale 1ns/1ps

module dtlb_ctrl (
  input  logic                 clkrst_mem_clk,
  input  logic                 clkrst_mem_rst_n,

  // Request side
  input  dtlb_pkg::vpn_t       dtlb_vpn,
  input  logic                 dtlb_re,
  input  logic                 dtlb_is_write,
  input  logic                 user_mode,
  input  logic                 paging_on,
  input  logic                 dtlb_clear,
  output logic                 dtlb_ready,

  // Page-table walker
  output dtlb_pkg::vpn_t       tlb2ptw_addr,
  output logic                 tlb2ptw_re,
  input  dtlb_pkg::ppn_t       tlb2ptw_phys_addr,
  input  logic                 tlb2ptw_ready,
  input  dtlb_pkg::pte_flags_t tlb2ptw_pagetab_flags,
  input  dtlb_pkg::pte_flags_t tlb2ptw_pagedir_flags,

  // Latched request, used by the fault check
  output dtlb_pkg::vpn_t       req_vpn,
  output logic                 req_re,
  output logic                 req_is_write,
  output logic                 req_user,
  output logic                 req_paging,

  dtlb_array_if.ctrl           arr
);
  import dtlb_pkg::*;

  dtlb_state_e state_q;
  dtlb_state_e state_d;
  logic        accept;
  logic        walk_done;
  logic        pending_clear_q;

  // Ready in IDLE, or in COMPARE once the tag compare hit
  assign dtlb_ready = (state_q == IDLE) || ((state_q == COMPARE) && arr.hit);

  // Request sampled at this edge
  assign accept = dtlb_ready && dtlb_re;

  // Walker answer ends the walk
  assign walk_done = (state_q == WALK) && tlb2ptw_ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Paging off completes without leaving IDLE
        if (accept && paging_on) begin
          state_d = COMPARE;
        end
      end
      COMPARE: begin
        if (!arr.hit) begin
          state_d = WALK;
        end else if (accept && paging_on) begin
          // Back-to-back hits stay in COMPARE
          state_d = COMPARE;
        end else begin
          state_d = IDLE;
        end
      end
      WALK: begin
        // Walker back-pressure just stretches this state
        if (tlb2ptw_ready) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Set read uses the new VPN when a request is taken, else the latched one
  // Re-reading the latched VPN keeps the array output stable while idle
  assign arr.lookup_vpn = accept ? dtlb_vpn : req_vpn;

  // Replacement update for the hit being reported
  assign arr.hit_update = (state_q == COMPARE) && arr.hit;

  // Fill entry from the walker
  // Entry flags are the AND of directory and table flags
  assign arr.fill_we    = walk_done;
  assign arr.fill_vpn   = req_vpn;
  assign arr.fill_ppn   = tlb2ptw_phys_addr;
  assign arr.fill_flags = tlb2ptw_pagetab_flags & tlb2ptw_pagedir_flags;

  // Clear goes out only from IDLE, new or pending
  assign arr.clear = (state_q == IDLE) && (dtlb_clear || pending_clear_q);

  // One walker pulse per miss, address held from the request latch
  assign tlb2ptw_re   = (state_q == COMPARE) && !arr.hit;
  assign tlb2ptw_addr = req_vpn;

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      state_q         <= IDLE;
      pending_clear_q <= 1'b0;
      req_vpn         <= '0;
      req_re          <= 1'b0;
      req_is_write    <= 1'b0;
      req_user        <= 1'b0;
      req_paging      <= 1'b0;
    end else begin
      state_q <= state_d;

      // Clear outside IDLE waits here
      if (arr.clear) begin
        pending_clear_q <= 1'b0;
      end else if (dtlb_clear) begin
        pending_clear_q <= 1'b1;
      end

      // Request latch, results hold until the next accepted request
      if (accept) begin
        req_vpn      <= dtlb_vpn;
        req_re       <= dtlb_re;
        req_is_write <= dtlb_is_write;
        req_user     <= user_mode;
        req_paging   <= paging_on;
      end
    end
  end

  // Walker must see a single request pulse per walk
  a_walk_pulse: assert property (
    @(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    tlb2ptw_re |=> !tlb2ptw_re
  ) else $error("dtlb_ctrl: tlb2ptw_re high for two cycles");

  // Walker address must not move until the answer comes back
  a_walk_addr: assert property (
    @(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    (state_q == WALK) |-> $stable(tlb2ptw_addr)
  ) else $error("dtlb_ctrl: tlb2ptw_addr changed during a walk");

endmodule

/* dtlb_entry_array.sv */
`timescale 1ns/1ps

module dtlb_entry_array #(
  parameter int SET_BITS = 4
) (
  input logic         clkrst_mem_clk,
  input logic         clkrst_mem_rst_n,
  dtlb_array_if.array arr
);
  import dtlb_pkg::*;

  // Low VPN bits pick the set, the rest is the tag
  localparam int TAG_BITS = $bits(vpn_t) - SET_BITS;
  localparam int NUM_SETS = 1 << SET_BITS;

  typedef logic [TAG_BITS-1:0] tag_t;
  typedef logic [SET_BITS-1:0] set_t;

  // Storage for 2 ways
  logic [NUM_SETS-1:0] valid_q [2];
  tag_t                tag_q   [2][NUM_SETS];
  ppn_t                ppn_q   [2][NUM_SETS];
  pte_flags_t          flags_q [2][NUM_SETS];

  // Way to evict next, one bit per set
  logic [NUM_SETS-1:0] evict_q;

  // Set of the compare whose result is on arr.hit
  set_t cmp_set_q;

  set_t       lookup_set;
  tag_t       lookup_tag;
  set_t       fill_set;
  tag_t       fill_tag;
  logic [1:0] match;
  logic       victim;

  assign lookup_set = arr.lookup_vpn[SET_BITS-1:0];
  assign lookup_tag = arr.lookup_vpn[$bits(vpn_t)-1:SET_BITS];
  assign fill_set   = arr.fill_vpn[SET_BITS-1:0];
  assign fill_tag   = arr.fill_vpn[$bits(vpn_t)-1:SET_BITS];
  assign victim     = evict_q[fill_set];

  // Tag compare on both ways
  // A clear at this edge wipes the set, so it cannot count as a hit
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      match[w] = valid_q[w][lookup_set] && (tag_q[w][lookup_set] == lookup_tag) &&
                 !arr.clear;
    end
  end

  // Valid bits and replacement bits
  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      evict_q    <= '0;
    end else if (arr.clear) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
    end else begin
      // New entry lands in the victim way, the other way goes next
      if (arr.fill_we) begin
        valid_q[victim][fill_set] <= 1'b1;
        evict_q[fill_set]         <= ~victim;
      end
      // After a hit, evict the way that did not hit
      if (arr.hit_update) begin
        evict_q[cmp_set_q] <= ~arr.hit_way;
      end
    end
  end

  // Tag and translation storage
  always_ff @(posedge clkrst_mem_clk) begin
    if (arr.fill_we) begin
      tag_q[victim][fill_set]   <= fill_tag;
      ppn_q[victim][fill_set]   <= arr.fill_ppn;
      flags_q[victim][fill_set] <= arr.fill_flags;
    end
  end

  // Registered compare result
  // A fill reports itself as a hit on the way it was written to
  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      arr.hit     <= 1'b0;
      arr.hit_way <= 1'b0;
      cmp_set_q   <= '0;
    end else if (arr.fill_we) begin
      arr.hit     <= 1'b1;
      arr.hit_way <= victim;
      cmp_set_q   <= fill_set;
    end else begin
      arr.hit     <= |match;
      arr.hit_way <= match[1];
      cmp_set_q   <= lookup_set;
    end
  end

  // Registered translation
  // On a miss the previous translation stays, so results hold between requests
  always_ff @(posedge clkrst_mem_clk) begin
    if (arr.fill_we) begin
      arr.entry_ppn   <= arr.fill_ppn;
      arr.entry_flags <= arr.fill_flags;
    end else if (|match) begin
      arr.entry_ppn   <= ppn_q[match[1]][lookup_set];
      arr.entry_flags <= flags_q[match[1]][lookup_set];
    end
  end

  // A filled VPN is found by the next compare unless a clear wipes it
  a_fill_then_hit: assert property (
    @(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    (arr.fill_we ##1 (arr.lookup_vpn == $past(arr.fill_vpn) && !arr.clear)) |=> arr.hit
  ) else $error("dtlb_entry_array: filled VPN missed on the next compare");

  // Fills only follow misses, so a VPN lives in one way at most
  a_single_way: assert property (
    @(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    !(match[0] && match[1])
  ) else $error("dtlb_entry_array: both ways hit");

endmodule

/* dtlb_fault_check.sv */
`timescale 1ns/1ps

module dtlb_fault_check (
  // Latched request
  input  dtlb_pkg::vpn_t       req_vpn,
  input  logic                 req_re,
  input  logic                 req_is_write,
  input  logic                 req_user,
  input  logic                 req_paging,

  // Cached translation from the array
  input  dtlb_pkg::ppn_t       entry_ppn,
  input  dtlb_pkg::pte_flags_t entry_flags,

  // Result
  output dtlb_pkg::ppn_t       dtlb_ppn,
  output dtlb_pkg::pte_flags_t dtlb_flags,
  output logic                 dtlb_pf
);
  import dtlb_pkg::*;

  logic page_present;
  logic page_writable;
  logic page_user;

  // Paging off maps the page number to itself
  assign dtlb_ppn   = req_paging ? entry_ppn : ppn_t'(req_vpn);
  assign dtlb_flags = req_paging ? entry_flags : FLAGS_PASSTHRU;

  assign page_present  = dtlb_flags[FLAG_PRESENT];
  assign page_writable = dtlb_flags[FLAG_WRITABLE];
  assign page_user     = dtlb_flags[FLAG_USER];

  // Fault rules, only for a read-enabled request
  always_comb begin
    dtlb_pf = 1'b0;
    if (req_re) begin
      if (!page_present) begin
        dtlb_pf = 1'b1;
      end else if (req_user && !page_user) begin
        // User access to a kernel page
        dtlb_pf = 1'b1;
      end else if (req_is_write && !page_writable) begin
        // Store to a read-only page
        dtlb_pf = 1'b1;
      end
    end
  end

endmodule

/* dtlb_pkg.sv */
package dtlb_pkg;

  // Page numbers for 4 KiB pages in a 32-bit address space
  typedef logic [19:0] vpn_t;
  typedef logic [19:0] ppn_t;

  // Entry flags
  // Bit 3 is reserved and carried through untouched
  typedef logic [3:0] pte_flags_t;

  // Bit positions inside pte_flags_t
  localparam int FLAG_PRESENT  = 0;
  localparam int FLAG_WRITABLE = 1;
  localparam int FLAG_USER     = 2;

  // Paging off reports a present, writable, kernel-only page
  localparam pte_flags_t FLAGS_PASSTHRU = pte_flags_t'(
    (1 << FLAG_PRESENT) | (1 << FLAG_WRITABLE)
  );

  // Lookup controller states
  typedef enum logic [1:0] {
    // Waiting for a request, array read uses the incoming VPN
    IDLE,
    // Tag compare result of the accepted request is available
    COMPARE,
    // Waiting on the page-table walker
    WALK
  } dtlb_state_e;

endpackage

/* dtlb_top.sv */
`timescale 1ns/1ps

module dtlb_top #(
  parameter int SET_BITS = 4
) (
  input  logic                 clkrst_mem_clk,
  input  logic                 clkrst_mem_rst_n,

  // Request side
  input  dtlb_pkg::vpn_t       dtlb_vpn,
  input  logic                 dtlb_re,
  input  logic                 dtlb_is_write,
  input  logic                 user_mode,
  input  logic                 paging_on,
  input  logic                 dtlb_clear,

  // Result side
  output dtlb_pkg::ppn_t       dtlb_ppn,
  output dtlb_pkg::pte_flags_t dtlb_flags,
  output logic                 dtlb_pf,
  output logic                 dtlb_ready,

  // Page-table walker
  output dtlb_pkg::vpn_t       tlb2ptw_addr,
  output logic                 tlb2ptw_re,
  input  dtlb_pkg::ppn_t       tlb2ptw_phys_addr,
  input  logic                 tlb2ptw_ready,
  input  dtlb_pkg::pte_flags_t tlb2ptw_pagetab_flags,
  input  dtlb_pkg::pte_flags_t tlb2ptw_pagedir_flags
);
  import dtlb_pkg::*;

  // Latched request from the controller to the fault check
  vpn_t req_vpn;
  logic req_re;
  logic req_is_write;
  logic req_user;
  logic req_paging;

  dtlb_array_if arr_if ();

  dtlb_ctrl u_ctrl (
    .clkrst_mem_clk        (clkrst_mem_clk),
    .clkrst_mem_rst_n      (clkrst_mem_rst_n),
    .dtlb_vpn              (dtlb_vpn),
    .dtlb_re               (dtlb_re),
    .dtlb_is_write         (dtlb_is_write),
    .user_mode             (user_mode),
    .paging_on             (paging_on),
    .dtlb_clear            (dtlb_clear),
    .dtlb_ready            (dtlb_ready),
    .tlb2ptw_addr          (tlb2ptw_addr),
    .tlb2ptw_re            (tlb2ptw_re),
    .tlb2ptw_phys_addr     (tlb2ptw_phys_addr),
    .tlb2ptw_ready         (tlb2ptw_ready),
    .tlb2ptw_pagetab_flags (tlb2ptw_pagetab_flags),
    .tlb2ptw_pagedir_flags (tlb2ptw_pagedir_flags),
    .req_vpn               (req_vpn),
    .req_re                (req_re),
    .req_is_write          (req_is_write),
    .req_user              (req_user),
    .req_paging            (req_paging),
    .arr                   (arr_if.ctrl)
  );

  dtlb_entry_array #(
    .SET_BITS (SET_BITS)
  ) u_entry_array (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .arr              (arr_if.array)
  );

  dtlb_fault_check u_fault_check (
    .req_vpn      (req_vpn),
    .req_re       (req_re),
    .req_is_write (req_is_write),
    .req_user     (req_user),
    .req_paging   (req_paging),
    .entry_ppn    (arr_if.entry_ppn),
    .entry_flags  (arr_if.entry_flags),
    .dtlb_ppn     (dtlb_ppn),
    .dtlb_flags   (dtlb_flags),
    .dtlb_pf      (dtlb_pf)
  );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_dtlb -o tb_dtlb_sim
./obj_dir/tb_dtlb_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb_dtlb.sv */
`timescale 1ns/1ps

module tb_dtlb;
  import dtlb_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS  = 5;

  logic       clkrst_mem_clk;
  logic       clkrst_mem_rst_n;
  vpn_t       dtlb_vpn;
  logic       dtlb_re;
  logic       dtlb_is_write;
  logic       user_mode;
  logic       paging_on;
  logic       dtlb_clear;
  ppn_t       dtlb_ppn;
  pte_flags_t dtlb_flags;
  logic       dtlb_pf;
  logic       dtlb_ready;
  vpn_t       tlb2ptw_addr;
  logic       tlb2ptw_re;
  ppn_t       tlb2ptw_phys_addr;
  logic       tlb2ptw_ready;
  pte_flags_t tlb2ptw_pagetab_flags;
  pte_flags_t tlb2ptw_pagedir_flags;

  // Walker pulses seen so far, and the address of the last one
  int   walk_count;
  vpn_t walk_addr;
  // Walker pulses caused by the last access
  int   last_walks;
  // Cycles dtlb_ready stayed low after the last access
  int   last_wait;
  int   error_count;
  int   check_count;

  dtlb_top #(.SET_BITS(4)) dut0 (
    .clkrst_mem_clk (clkrst_mem_clk), .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .dtlb_vpn (dtlb_vpn), .dtlb_re (dtlb_re), .dtlb_is_write (dtlb_is_write),
    .user_mode (user_mode), .paging_on (paging_on), .dtlb_clear (dtlb_clear),
    .dtlb_ppn (dtlb_ppn), .dtlb_flags (dtlb_flags), .dtlb_pf (dtlb_pf),
    .dtlb_ready (dtlb_ready), .tlb2ptw_addr (tlb2ptw_addr), .tlb2ptw_re (tlb2ptw_re),
    .tlb2ptw_phys_addr (tlb2ptw_phys_addr), .tlb2ptw_ready (tlb2ptw_ready),
    .tlb2ptw_pagetab_flags (tlb2ptw_pagetab_flags),
    .tlb2ptw_pagedir_flags (tlb2ptw_pagedir_flags)
  );

  tb_ptw_model ptw0 (
    .clkrst_mem_clk (clkrst_mem_clk), .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .tlb2ptw_addr (tlb2ptw_addr), .tlb2ptw_re (tlb2ptw_re),
    .tlb2ptw_phys_addr (tlb2ptw_phys_addr), .tlb2ptw_ready (tlb2ptw_ready),
    .tlb2ptw_pagetab_flags (tlb2ptw_pagetab_flags),
    .tlb2ptw_pagedir_flags (tlb2ptw_pagedir_flags)
  );

  initial clkrst_mem_clk = 1'b0;
  always #(CLK_PERIOD / 2) clkrst_mem_clk = ~clkrst_mem_clk;

  // Walker requests counted mid-cycle, where tlb2ptw_re is settled
  always @(negedge clkrst_mem_clk) begin
    if (clkrst_mem_rst_n && tlb2ptw_re) begin
      walk_count = walk_count + 1;
      walk_addr  = tlb2ptw_addr;
    end
  end

  // Page the walker model returns for a VPN
  function automatic ppn_t mapped_ppn(input vpn_t vpn);
    return vpn ^ 20'hA5A5A;
  endfunction

  task automatic report_mismatch(input string msg);
    error_count = error_count + 1;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  // One request, strobed for a cycle, then wait for dtlb_ready
  task automatic access(input vpn_t vpn, input logic write, input logic user,
                        input logic paging, input logic clear_in_walk);
    int start;
    @(negedge clkrst_mem_clk);
    while (!dtlb_ready) @(negedge clkrst_mem_clk);
    start         = walk_count;
    dtlb_vpn      = vpn;
    dtlb_re       = 1'b1;
    dtlb_is_write = write;
    user_mode     = user;
    paging_on     = paging;
    @(negedge clkrst_mem_clk);
    dtlb_re    = 1'b0;
    // Clear strobed while the miss is still in progress
    dtlb_clear = clear_in_walk;
    last_wait  = 0;
    while (!dtlb_ready) begin
      @(negedge clkrst_mem_clk);
      dtlb_clear = 1'b0;
      last_wait  = last_wait + 1;
    end
    dtlb_clear = 1'b0;
    last_walks = walk_count - start;
  endtask

  task automatic expect_result(input string what, input ppn_t ppn, input pte_flags_t flags,
                               input logic pf, input int walks);
    check_count = check_count + 1;
    if (dtlb_ppn !== ppn)
      report_mismatch($sformatf("%s: dtlb_ppn %h, expected %h", what, dtlb_ppn, ppn));
    if (dtlb_flags !== flags)
      report_mismatch($sformatf("%s: dtlb_flags %b, expected %b", what, dtlb_flags, flags));
    if (dtlb_pf !== pf)
      report_mismatch($sformatf("%s: dtlb_pf %b, expected %b", what, dtlb_pf, pf));
    if (last_walks != walks)
      report_mismatch($sformatf("%s: %0d walks, expected %0d", what, last_walks, walks));
    if (walks == 1 && walk_addr !== dtlb_vpn)
      report_mismatch($sformatf("%s: walk address %h, expected %h", what, walk_addr, dtlb_vpn));
    // Hits and paging off answer in the next cycle, a miss keeps ready low
    if ((walks == 0) != (last_wait == 0))
      report_mismatch($sformatf("%s: dtlb_ready low for %0d cycles", what, last_wait));
  endtask

  task automatic print_test_line(input string name, input int errors_before);
    $display("%-18s %0d errors", name, error_count - errors_before);
  endtask

  task automatic paging_off_passthrough();
    int errs;
    errs = error_count;
    access(20'h12345, 1'b1, 1'b0, 1'b0, 1'b0);
    expect_result("kernel write", 20'h12345, 4'b0011, 1'b0, 0);
    access(20'h54321, 1'b0, 1'b1, 1'b0, 1'b0);
    expect_result("user read", 20'h54321, 4'b0011, 1'b1, 0);
    print_test_line("paging off", errs);
  endtask

  task automatic miss_then_hit();
    int errs;
    errs = error_count;
    access(20'h0002F, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("first access", mapped_ppn(20'h0002F), 4'hF, 1'b0, 1);
    access(20'h0002F, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("repeat access", mapped_ppn(20'h0002F), 4'hF, 1'b0, 0);
    print_test_line("miss then hit", errs);
  endtask

  task automatic fault_rules();
    int errs;
    errs = error_count;
    // Low nibble 6 lacks present, 3 lacks user, 5 lacks writable
    access(20'h00046, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("not present", mapped_ppn(20'h00046), 4'h6, 1'b1, 1);
    access(20'h00053, 1'b0, 1'b1, 1'b1, 1'b0);
    expect_result("kernel page, user", mapped_ppn(20'h00053), 4'h3, 1'b1, 1);
    access(20'h00053, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("kernel page, kernel", mapped_ppn(20'h00053), 4'h3, 1'b0, 0);
    access(20'h00065, 1'b1, 1'b0, 1'b1, 1'b0);
    expect_result("read-only, write", mapped_ppn(20'h00065), 4'h5, 1'b1, 1);
    access(20'h00065, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("read-only, read", mapped_ppn(20'h00065), 4'h5, 1'b0, 0);
    // Faulting inputs without the strobe are never sampled
    dtlb_vpn      = 20'h00046;
    dtlb_is_write = 1'b1;
    user_mode     = 1'b1;
    repeat (4) begin
      @(negedge clkrst_mem_clk);
      if (dtlb_pf !== 1'b0) report_mismatch("dtlb_pf raised while dtlb_re is low");
    end
    print_test_line("faults", errs);
  endtask

  task automatic way_replacement();
    int errs;
    errs = error_count;
    // All three land in set 7
    access(20'h10007, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("A fill", mapped_ppn(20'h10007), 4'h7, 1'b0, 1);
    access(20'h20007, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("B fill", mapped_ppn(20'h20007), 4'h7, 1'b0, 1);
    access(20'h10007, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("A hit", mapped_ppn(20'h10007), 4'h7, 1'b0, 0);
    access(20'h30007, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("C evicts B", mapped_ppn(20'h30007), 4'h7, 1'b0, 1);
    access(20'h10007, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("A kept", mapped_ppn(20'h10007), 4'h7, 1'b0, 0);
    access(20'h20007, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("B walks again", mapped_ppn(20'h20007), 4'h7, 1'b0, 1);
    print_test_line("replacement", errs);
  endtask

  task automatic clear_invalidates();
    int errs;
    errs = error_count;
    access(20'h0008B, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("D fill", mapped_ppn(20'h0008B), 4'hB, 1'b0, 1);
    access(20'h0008B, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("D hit", mapped_ppn(20'h0008B), 4'hB, 1'b0, 0);
    // Clear in idle
    @(negedge clkrst_mem_clk);
    dtlb_clear = 1'b1;
    @(negedge clkrst_mem_clk);
    dtlb_clear = 1'b0;
    access(20'h0008B, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("D after clear", mapped_ppn(20'h0008B), 4'hB, 1'b0, 1);
    // Clear during the walk is applied after the fill
    access(20'h0009D, 1'b0, 1'b0, 1'b1, 1'b1);
    expect_result("E clear in walk", mapped_ppn(20'h0009D), 4'hD, 1'b0, 1);
    access(20'h0009D, 1'b0, 1'b0, 1'b1, 1'b0);
    expect_result("E walks again", mapped_ppn(20'h0009D), 4'hD, 1'b0, 1);
    print_test_line("clear", errs);
  endtask

  // Watchdog, 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    walk_count       = 0;
    walk_addr        = '0;
    last_walks       = 0;
    last_wait        = 0;
    error_count      = 0;
    check_count      = 0;
    clkrst_mem_rst_n = 1'b0;
    dtlb_vpn         = '0;
    dtlb_re          = 1'b0;
    dtlb_is_write    = 1'b0;
    user_mode        = 1'b0;
    paging_on        = 1'b0;
    dtlb_clear       = 1'b0;
    repeat (10) @(negedge clkrst_mem_clk);
    clkrst_mem_rst_n = 1'b1;
    paging_off_passthrough();
    miss_then_hit();
    fault_rules();
    way_replacement();
    clear_invalidates();
    $display("%0d tests, %0d result checks, %0d errors", NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb_ptw_model.sv */
`timescale 1ns/1ps

module tb_ptw_model (
  input  logic                 clkrst_mem_clk,
  input  logic                 clkrst_mem_rst_n,
  input  dtlb_pkg::vpn_t       tlb2ptw_addr,
  input  logic                 tlb2ptw_re,
  output dtlb_pkg::ppn_t       tlb2ptw_phys_addr,
  output logic                 tlb2ptw_ready,
  output dtlb_pkg::pte_flags_t tlb2ptw_pagetab_flags,
  output dtlb_pkg::pte_flags_t tlb2ptw_pagedir_flags
);
  import dtlb_pkg::*;

  integer seed;
  int     wait_cycles;
  logic   busy;
  vpn_t   walk_vpn;

  // Walker runs on the falling edge, the DUT samples its answer on the rising edge
  initial begin
    seed                  = 40;
    busy                  = 1'b0;
    wait_cycles           = 0;
    walk_vpn              = '0;
    tlb2ptw_ready         = 1'b0;
    tlb2ptw_phys_addr     = '0;
    tlb2ptw_pagetab_flags = '0;
    tlb2ptw_pagedir_flags = '0;
    forever begin
      @(negedge clkrst_mem_clk);
      // Answer is a single-cycle level
      tlb2ptw_ready = 1'b0;
      if (!clkrst_mem_rst_n) begin
        busy = 1'b0;
      end else if (busy) begin
        if (wait_cycles == 0) begin
          // Fixed translation rule
          tlb2ptw_phys_addr     = walk_vpn ^ 20'hA5A5A;
          tlb2ptw_pagetab_flags = walk_vpn[3:0];
          tlb2ptw_pagedir_flags = 4'hF;
          tlb2ptw_ready         = 1'b1;
          busy                  = 1'b0;
        end else begin
          wait_cycles = wait_cycles - 1;
        end
      end else if (tlb2ptw_re) begin
        // New walk, latency of 1 to 8 cycles
        walk_vpn    = tlb2ptw_addr;
        wait_cycles = $random(seed) & 7;
        busy        = 1'b1;
      end
    end
  end

endmodule
